// File: bench/tb_checker.sv
// Reference model and output checker
`timescale 1ns/1ps

module tb_checker #(
   parameter logic [15:0] MOD_VENDOR      = 16'h0000,
   parameter logic [15:0] MOD_TYPE        = 16'h0000,
   parameter logic [15:0] MOD_VERSION     = 16'h0000,
   parameter logic [15:0] MOD_EVENT_DEST  = 16'h0000,
   parameter logic [15:0] THRESHOLD_RESET = 16'h0004
) (
   input logic        clk,
   input logic        rst,
   input logic [15:0] id,
   input logic [15:0] in_data,
   input logic        in_last,
   input logic        in_valid,
   input logic        in_ready,
   input logic [15:0] out_data,
   input logic        out_last,
   input logic        out_valid,
   input logic        out_ready,
   input logic [15:0] sample_data,
   input logic        sample_valid,
   input logic        sample_ready,
   input logic        stall
);
   import dii_pkg::*;

   logic [15:0] req_words[$];     // Request packet being received
   logic [15:0] out_words[$];     // Output packet being collected
   logic [15:0] exp_resp[$];      // Expected responses, all words in a row
   int          exp_resp_len[$];
   logic [15:0] exp_sum[$];       // One sum per expected event
   logic [15:0] exp_pkt[$];
   int          value_errors = 0;
   int          proto_errors = 0;
   logic        m_active;
   logic [15:0] m_threshold;
   logic [15:0] m_count;
   logic [15:0] m_sum;

   task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
      if (exp !== act) begin
         value_errors++;
         $display("Fail at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
      end
   endtask

   task automatic model_sample(input logic [15:0] d);
      logic [15:0] limit;
      if (!m_active) begin
         return;                                // Taken and dropped
      end
      limit   = (m_threshold == 16'h0000) ? 16'h0001 : m_threshold;
      m_count = m_count + 16'h0001;
      m_sum   = m_sum + d;
      if (m_count >= limit) begin
         exp_sum.push_back(m_sum);
         m_count = 16'h0000;
         m_sum   = 16'h0000;
      end
   endtask

   // Expected answer for the request packet in req_words
   task automatic model_request();
      logic [15:0] flags;
      logic [15:0] addr;
      logic [15:0] value;
      logic [3:0]  sub;
      logic        ok;
      int          n;
      n = req_words.size();
      if (n < 4 || req_words[2][15:14] != TYPE_REG) begin
         return;
      end
      flags = req_words[2];
      addr  = req_words[3];
      value = 16'h0000;
      ok    = 1'b1;
      if (!flags[12]) begin
         if (n != 4) begin
            return;                             // Trailing flits
         end
         if (addr == REG_THRESHOLD && flags[11:10] == SIZE_16) value = m_threshold;
         else if (addr == REG_COUNT && flags[11:10] == SIZE_16) value = m_count;
         else if (addr == REG_MOD_VENDOR) value = MOD_VENDOR;
         else if (addr == REG_MOD_TYPE) value = MOD_TYPE;
         else if (addr == REG_MOD_VERSION) value = MOD_VERSION;
         else if (addr == REG_MOD_CS) value = {15'h0000, m_active};
         else if (addr == REG_MOD_EVENT_DEST) value = MOD_EVENT_DEST;
         else ok = 1'b0;
         sub = ok ? {SUB_READ_OK, flags[11:10]} : SUB_READ_ERR;
      end else begin
         if (n > 5) begin
            return;
         end
         ok = (n == 5) && (flags[11:10] == SIZE_16);
         if (ok && addr == REG_MOD_CS) m_active = req_words[4][0];
         else if (ok && addr == REG_THRESHOLD) m_threshold = req_words[4];
         else ok = 1'b0;
         sub = ok ? SUB_WRITE_OK : SUB_WRITE_ERR;
      end
      exp_resp.push_back(req_words[1]);         // Back to the requester
      exp_resp.push_back(id);
      exp_resp.push_back({TYPE_REG, sub, 10'h000});
      if (!flags[12] && ok) begin
         exp_resp.push_back(value);
         exp_resp_len.push_back(4);
      end else begin
         exp_resp_len.push_back(3);
      end
   endtask

   task automatic check_packet();
      int n;
      int len;
      n = out_words.size();
      exp_pkt.delete();
      if (n < 3) begin
         proto_errors++;
         $display("Output packet at %0t ns has only %0d words", $time, n);
         return;
      end
      if (out_words[2][15:14] == TYPE_EVENT) begin
         if (exp_sum.size() == 0) begin
            proto_errors++;
            $display("Event packet at %0t ns was not expected", $time);
            return;
         end
         exp_pkt.push_back(MOD_EVENT_DEST);
         exp_pkt.push_back(id);
         exp_pkt.push_back({TYPE_EVENT, 14'h0000});
         exp_pkt.push_back(exp_sum.pop_front());
      end else begin
         if (exp_resp_len.size() == 0) begin
            proto_errors++;
            $display("Response packet at %0t ns was not expected", $time);
            return;
         end
         len = exp_resp_len.pop_front();
         for (int i = 0; i < len; i++) begin
            exp_pkt.push_back(exp_resp.pop_front());
         end
      end
      if (n != exp_pkt.size()) begin
         proto_errors++;
         $display("Output packet at %0t ns has %0d words instead of %0d", $time, n,
                  exp_pkt.size());
      end else begin
         for (int i = 0; i < n; i++) begin
            compare($sformatf("out_data word %0d", i), exp_pkt[i], out_words[i]);
         end
      end
   endtask

   // Mid-cycle, everything is settled; a handshake seen here completes at the next edge
   always @(negedge clk) begin
      if (rst) begin
         m_active    = 1'b0;
         m_threshold = THRESHOLD_RESET;
         m_count     = 16'h0000;
         m_sum       = 16'h0000;
         req_words.delete();
         out_words.delete();
      end else begin
         if (stall !== !m_active) begin
            value_errors++;
            $display("Fail at %0t ns: stall expected %b, actual %b", $time, !m_active, stall);
         end
         if (sample_valid && sample_ready) begin
            model_sample(sample_data);          // Uses the active bit before this edge
         end
         if (in_valid && in_ready) begin
            req_words.push_back(in_data);
            if (in_last) begin
               model_request();
               req_words.delete();
            end
         end
         if (out_valid && out_ready) begin
            out_words.push_back(out_data);
            if (out_last) begin
               check_packet();
               out_words.delete();
            end
         end
      end
   end

   function automatic int outstanding();
      return exp_resp_len.size() + exp_sum.size();
   endfunction

   task automatic finish_check(output int total);
      int missing;
      missing = outstanding();
      if (missing != 0) begin
         $display("%0d expected packets never came out", missing);
      end
      total = value_errors + proto_errors + missing;
      $display("Checks done: %0d value errors, %0d protocol errors, %0d missing packets",
               value_errors, proto_errors, missing);
   endtask

endmodule

// File: bench/tb_dbg_module.sv
// Debug module testbench
`timescale 1ns/1ps

module tb_dbg_module;
   import dii_pkg::*;

   localparam logic [15:0] VENDOR     = 16'h0005;
   localparam logic [15:0] MTYPE      = 16'h0012;
   localparam logic [15:0] VERSION    = 16'h0003;
   localparam logic [15:0] EVENT_DEST = 16'h00a0;
   localparam logic [15:0] THRESH_RST = 16'h0004;
   localparam int          LIMIT      = 400;     // Cycles any single wait may take

   logic        clk;
   logic        rst;
   logic [15:0] id;
   logic [15:0] in_data;
   logic        in_last;
   logic        in_valid;
   logic        in_ready;
   logic [15:0] out_data;
   logic        out_last;
   logic        out_valid;
   logic        out_ready;
   logic [15:0] sample_data;
   logic        sample_valid;
   logic        sample_ready;
   logic        stall;
   logic [15:0] lfsr = 16'd19499;
   logic [15:0] ready_bits;
   logic [15:0] pkt_words[$];

   dbg_module #(
      .MOD_VENDOR      (VENDOR),
      .MOD_TYPE        (MTYPE),
      .MOD_VERSION     (VERSION),
      .MOD_EVENT_DEST  (EVENT_DEST),
      .CAN_STALL       (1'b1),
      .THRESHOLD_RESET (THRESH_RST)
   ) u_dut (.*);

   tb_checker #(
      .MOD_VENDOR      (VENDOR),
      .MOD_TYPE        (MTYPE),
      .MOD_VERSION     (VERSION),
      .MOD_EVENT_DEST  (EVENT_DEST),
      .THRESHOLD_RESET (THRESH_RST)
   ) u_check (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      logic        fb;
      v = 16'h0000;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5];
         lfsr = {fb, lfsr[15:1]};
         v    = {v[14:0], fb};
      end
      return v;
   endfunction

   task automatic abort_run(input string why);
      int errs;
      $display("Timeout: %s", why);
      u_check.finish_check(errs);
      $display("*** FAILED ***");
      $finish;
   endtask

   // Every task starts and ends 1 ns after a rising edge
   task automatic send_request(input logic [1:0] typ, input logic wr, input logic [1:0] size,
                               input logic [15:0] addr, input logic [15:0] wdata,
                               input logic with_data, input int extra);
      logic [15:0] r;
      int          waited;
      pkt_words.delete();
      pkt_words.push_back(id);                   // Every packet counts as addressed here
      pkt_words.push_back(rand_bits(16));        // Source
      pkt_words.push_back({typ, 1'b0, wr, size, 10'h000});
      pkt_words.push_back(addr);
      if (with_data) begin
         pkt_words.push_back(wdata);
      end
      for (int i = 0; i < extra; i++) begin
         pkt_words.push_back(rand_bits(16));
      end
      for (int i = 0; i < pkt_words.size(); i++) begin
         r = rand_bits(2);
         if (r[1:0] == 2'b00) begin
            @(posedge clk);                      // Idle gap
            #1;
         end
         in_data  = pkt_words[i];
         in_last  = (i == pkt_words.size() - 1);
         in_valid = 1'b1;
         waited   = 0;
         do begin
            @(negedge clk);
            waited++;
            if (waited > LIMIT) abort_run("request flit was never accepted");
         end while (!in_ready);
         @(posedge clk);
         #1;
         in_valid = 1'b0;
         in_last  = 1'b0;
      end
   endtask

   task automatic send_samples(input int n);
      logic [15:0] r;
      int          waited;
      for (int k = 0; k < n; k++) begin
         r = rand_bits(2);
         if (r[1:0] == 2'b00) begin
            @(posedge clk);
            #1;
         end
         sample_data  = rand_bits(16);
         sample_valid = 1'b1;
         waited       = 0;
         do begin
            @(negedge clk);
            waited++;
            if (waited > LIMIT) abort_run("sample was never accepted");
         end while (!sample_ready);
         @(posedge clk);
         #1;
         sample_valid = 1'b0;
      end
   endtask

   // Base reads, address 5 for a read error, foreign packets and MOD_CS writes
   task automatic random_requests(input int n);
      logic [15:0] pick;
      logic [15:0] r;
      for (int k = 0; k < n; k++) begin
         pick = rand_bits(3);
         r    = rand_bits(2);
         case (pick[2:0])
            3'd6: send_request(TYPE_EVENT, 1'b0, SIZE_16, rand_bits(16), 16'h0, 1'b0, r[1:0]);
            3'd7: send_request(TYPE_REG, 1'b1, SIZE_16, REG_MOD_CS, {15'h0, r[0]}, 1'b1, 0);
            default: send_request(TYPE_REG, 1'b0, r[1:0], pick, 16'h0, 1'b0, 0);
         endcase
      end
   endtask

   initial begin
      forever begin
         @(posedge clk);
         #1;
         ready_bits = rand_bits(2);
         out_ready  = (ready_bits[1:0] != 2'b00);   // Back-pressure about one cycle in four
      end
   end

   initial begin
      int          errs;
      int          waited;
      logic [15:0] r;
      rst          = 1'b1;
      id           = 16'h0042;
      in_data      = 16'h0000;
      in_last      = 1'b0;
      in_valid     = 1'b0;
      out_ready    = 1'b0;
      sample_data  = 16'h0000;
      sample_valid = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;

      for (int s = 0; s < 4; s++) begin
         for (int a = 0; a < 5; a++) begin
            send_request(TYPE_REG, 1'b0, s[1:0], a[15:0], 16'h0, 1'b0, 0);
         end
      end
      send_request(TYPE_REG, 1'b1, SIZE_16, REG_MOD_CS, 16'h0001, 1'b1, 0);
      send_request(TYPE_REG, 1'b0, SIZE_16, REG_MOD_CS, 16'h0000, 1'b0, 0);
      send_request(TYPE_REG, 1'b1, SIZE_16, REG_MOD_CS, 16'hfffe, 1'b1, 0);
      send_request(TYPE_REG, 1'b0, SIZE_16, REG_MOD_CS, 16'h0000, 1'b0, 0);
      send_request(TYPE_REG, 1'b1, SIZE_16, REG_MOD_VENDOR, 16'h1234, 1'b1, 0);
      send_request(TYPE_REG, 1'b1, SIZE_32, REG_MOD_CS, 16'h0001, 1'b1, 0);
      send_request(TYPE_REG, 1'b1, SIZE_16, REG_MOD_CS, 16'h0001, 1'b0, 0);   // No data word
      send_request(TYPE_REG, 1'b0, SIZE_16, 16'h0007, 16'h0000, 1'b0, 0);
      send_request(TYPE_EVENT, 1'b0, SIZE_16, 16'h1234, 16'h0000, 1'b0, 2);
      send_request(TYPE_REG, 1'b0, SIZE_16, REG_MOD_VENDOR, 16'h0000, 1'b0, 1);
      send_request(TYPE_REG, 1'b1, SIZE_16, REG_MOD_CS, 16'h0001, 1'b1, 1);
      send_request(TYPE_REG, 1'b0, SIZE_16, REG_MOD_VERSION, 16'h0000, 1'b0, 0);

      // Module registers over the register bus
      send_request(TYPE_REG, 1'b1, SIZE_16, REG_THRESHOLD, 16'h0003, 1'b1, 0);
      send_request(TYPE_REG, 1'b0, SIZE_16, REG_THRESHOLD, 16'h0000, 1'b0, 0);
      send_request(TYPE_REG, 1'b0, SIZE_16, REG_COUNT, 16'h0000, 1'b0, 0);
      send_request(TYPE_REG, 1'b1, SIZE_16, REG_COUNT, 16'h0009, 1'b1, 0);
      send_request(TYPE_REG, 1'b0, SIZE_16, 16'h0202, 16'h0000, 1'b0, 0);
      send_request(TYPE_REG, 1'b1, SIZE_16, 16'h0203, 16'h0001, 1'b1, 0);
      send_request(TYPE_REG, 1'b0, SIZE_32, REG_THRESHOLD, 16'h0000, 1'b0, 0);
      send_request(TYPE_REG, 1'b1, SIZE_64, REG_THRESHOLD, 16'h0002, 1'b1, 0);

      // Sample windows with traffic alongside, the last round at threshold 0
      for (int round = 0; round < 3; round++) begin
         r = rand_bits(3);
         send_request(TYPE_REG, 1'b1, SIZE_16, REG_THRESHOLD,
                      (round == 2) ? 16'h0000 : r + 16'h0001, 1'b1, 0);
         send_request(TYPE_REG, 1'b0, SIZE_16, REG_COUNT, 16'h0000, 1'b0, 0);
         send_request(TYPE_REG, 1'b1, SIZE_16, REG_MOD_CS, 16'h0001, 1'b1, 0);
         fork
            send_samples(40);
            random_requests(12);
         join
      end

      send_request(TYPE_REG, 1'b1, SIZE_16, REG_MOD_CS, 16'h0000, 1'b1, 0);
      send_samples(12);
      send_request(TYPE_REG, 1'b0, SIZE_16, REG_COUNT, 16'h0000, 1'b0, 0);
      send_request(TYPE_REG, 1'b0, SIZE_16, REG_MOD_CS, 16'h0000, 1'b0, 0);

      waited = 0;
      while (u_check.outstanding() != 0) begin
         @(posedge clk);
         #1;
         waited++;
         if (waited > LIMIT) abort_run("output packets still missing at the end");
      end
      repeat (5) @(posedge clk);

      u_check.finish_check(errs);
      if (errs == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: build.f
hw/dii_pkg.sv
hw/dii_if.sv
hw/reg_if.sv
hw/dbg_regaccess.sv
hw/dbg_event_unit.sv
hw/dbg_packet_mux.sv
hw/dbg_module.sv
bench/tb_checker.sv
bench/tb_dbg_module.sv

// File: hw/dbg_event_unit.sv
// Sample event unit
`timescale 1ns/1ps

module dbg_event_unit #(
   parameter logic [15:0] MOD_EVENT_DEST  = 16'h0000,
   parameter logic [15:0] THRESHOLD_RESET = 16'h0004
) (
   input  logic        clk,
   input  logic        rst,
   input  logic [15:0] id,
   input  logic        active,
   reg_if.slave        mreg,
   dii_if.sender       evt,
   input  logic [15:0] sample_data,
   input  logic        sample_valid,
   output logic        sample_ready
);
   import dii_pkg::*;

   localparam logic [2:0] E_IDLE = 3'd0, E_DEST = 3'd1, E_SRC = 3'd2;
   localparam logic [2:0] E_FLAGS = 3'd3, E_SUM = 3'd4;

   logic [15:0] threshold;
   logic [15:0] count, nxt_count;
   logic [15:0] sum, nxt_sum;
   logic [15:0] evt_sum;                // Sum of the finished window
   logic [15:0] limit;
   logic [2:0]  estate;
   logic        bus_start, bus_err;
   logic        smp_take, window_done;

   // A new access is one not yet answered
   assign bus_start = mreg.request && !mreg.ack && !mreg.err;

   always_comb begin
      bus_err = 1'b1;
      if (mreg.size == SIZE_16) begin
         if (mreg.addr == REG_THRESHOLD) begin
            bus_err = 1'b0;
         end else if (mreg.addr == REG_COUNT) begin
            bus_err = mreg.write;       // Count is read only
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         mreg.ack  <= 1'b0;
         mreg.err  <= 1'b0;
         threshold <= THRESHOLD_RESET;
      end else begin
         mreg.ack <= bus_start && !bus_err;
         mreg.err <= bus_start && bus_err;
         if (bus_start && !bus_err && mreg.write) begin
            threshold <= mreg.wdata;
         end
      end
      if (bus_start) begin
         mreg.rdata <= (mreg.addr == REG_COUNT) ? count : threshold;
      end
   end

   assign limit        = (threshold == 16'h0000) ? 16'h0001 : threshold;
   assign nxt_count    = count + 16'h0001;
   assign nxt_sum      = sum + sample_data;    // Wraps
   assign sample_ready = (estate == E_IDLE);   // Paused while an event is pending
   assign smp_take     = sample_valid && sample_ready && active;
   assign window_done  = smp_take && (nxt_count >= limit);

   always_ff @(posedge clk) begin
      if (rst) begin
         count  <= 16'h0000;
         sum    <= 16'h0000;
         estate <= E_IDLE;
      end else if (window_done) begin
         count  <= 16'h0000;
         sum    <= 16'h0000;
         estate <= E_DEST;
      end else if (smp_take) begin
         count <= nxt_count;
         sum   <= nxt_sum;
      end else if (evt.valid && evt.ready) begin
         estate <= (estate == E_SUM) ? E_IDLE : estate + 3'd1;
      end
      if (window_done) begin
         evt_sum <= nxt_sum;
      end
   end

   always_comb begin
      evt.valid = (estate != E_IDLE);
      evt.last  = (estate == E_SUM);
      case (estate)
         E_DEST:  evt.data = MOD_EVENT_DEST;
         E_SRC:   evt.data = id;
         E_FLAGS: evt.data = {TYPE_EVENT, 14'h0000};
         default: evt.data = evt_sum;
      endcase
   end

   a_ack_err_excl: assert property (@(posedge clk) disable iff (rst)
      !(mreg.ack && mreg.err));

endmodule

// File: hw/dbg_module.sv
// Debug module top level
`timescale 1ns/1ps

module dbg_module #(
   parameter logic [15:0] MOD_VENDOR      = 16'h0001,
   parameter logic [15:0] MOD_TYPE        = 16'h0002,
   parameter logic [15:0] MOD_VERSION     = 16'h0000,
   parameter logic [15:0] MOD_EVENT_DEST  = 16'h0000,
   parameter bit          CAN_STALL       = 1'b1,
   parameter logic [15:0] THRESHOLD_RESET = 16'h0004
) (
   input  logic        clk,
   input  logic        rst,
   input  logic [15:0] id,
   input  logic [15:0] in_data,
   input  logic        in_last,
   input  logic        in_valid,
   output logic        in_ready,
   output logic [15:0] out_data,
   output logic        out_last,
   output logic        out_valid,
   input  logic        out_ready,
   input  logic [15:0] sample_data,
   input  logic        sample_valid,
   output logic        sample_ready,
   output logic        stall
);

   dii_if req_ch ();
   dii_if resp_ch ();
   dii_if evt_ch ();
   reg_if mreg ();

   logic active;   // MOD_CS active bit

   assign req_ch.data  = in_data;
   assign req_ch.last  = in_last;
   assign req_ch.valid = in_valid;
   assign in_ready     = req_ch.ready;

   dbg_regaccess #(
      .MOD_VENDOR     (MOD_VENDOR),
      .MOD_TYPE       (MOD_TYPE),
      .MOD_VERSION    (MOD_VERSION),
      .MOD_EVENT_DEST (MOD_EVENT_DEST),
      .CAN_STALL      (CAN_STALL)
   ) u_regaccess (
      .clk    (clk),
      .rst    (rst),
      .id     (id),
      .req    (req_ch.receiver),
      .resp   (resp_ch.sender),
      .mreg   (mreg.master),
      .active (active),
      .stall  (stall)
   );

   dbg_event_unit #(
      .MOD_EVENT_DEST  (MOD_EVENT_DEST),
      .THRESHOLD_RESET (THRESHOLD_RESET)
   ) u_event_unit (
      .clk          (clk),
      .rst          (rst),
      .id           (id),
      .active       (active),
      .mreg         (mreg.slave),
      .evt          (evt_ch.sender),
      .sample_data  (sample_data),
      .sample_valid (sample_valid),
      .sample_ready (sample_ready)
   );

   // Responses on a, events on b
   dbg_packet_mux u_packet_mux (
      .clk       (clk),
      .rst       (rst),
      .in_a      (resp_ch.receiver),
      .in_b      (evt_ch.receiver),
      .out_data  (out_data),
      .out_last  (out_last),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

endmodule

// File: hw/dbg_packet_mux.sv
// Packet round-robin merge
`timescale 1ns/1ps

module dbg_packet_mux (
   input  logic        clk,
   input  logic        rst,
   dii_if.receiver     in_a,
   dii_if.receiver     in_b,
   output logic [15:0] out_data,
   output logic        out_last,
   output logic        out_valid,
   input  logic        out_ready
);

   logic [1:0] gnt_q;      // One-hot locked grant {b, a}, zero between packets
   logic       last_win;   // High when b won the previous packet
   logic       pick_b;
   logic       sel_b;
   logic       xfer;

   // Fresh pick only between packets, other side first on a tie
   assign pick_b = in_b.valid && (!in_a.valid || !last_win);
   assign sel_b  = (gnt_q != 2'b00) ? gnt_q[1] : pick_b;

   assign out_data  = sel_b ? in_b.data  : in_a.data;
   assign out_last  = sel_b ? in_b.last  : in_a.last;
   assign out_valid = sel_b ? in_b.valid : in_a.valid;

   assign in_a.ready = out_ready && !sel_b;
   assign in_b.ready = out_ready && sel_b;

   assign xfer = out_valid && out_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         gnt_q    <= 2'b00;
         last_win <= 1'b1;    // Input a goes first
      end else if (xfer) begin
         last_win <= sel_b;
         if (out_last) begin
            gnt_q <= 2'b00;
         end else begin
            gnt_q <= {sel_b, !sel_b};
         end
      end
   end

   // Lock holds until the last flit of the packet moves
   a_grant_locked: assert property (@(posedge clk) disable iff (rst)
      (gnt_q != 2'b00) && !(xfer && out_last) |=> $stable(gnt_q));

endmodule

// File: hw/dbg_regaccess.sv
// Register access block
`timescale 1ns/1ps

module dbg_regaccess #(
   parameter logic [15:0] MOD_VENDOR     = 16'h0000,
   parameter logic [15:0] MOD_TYPE       = 16'h0000,
   parameter logic [15:0] MOD_VERSION    = 16'h0000,
   parameter logic [15:0] MOD_EVENT_DEST = 16'h0000,
   parameter bit          CAN_STALL      = 1'b0
) (
   input  logic        clk,
   input  logic        rst,
   input  logic [15:0] id,
   dii_if.receiver     req,
   dii_if.sender       resp,
   reg_if.master       mreg,
   output logic        active,
   output logic        stall
);
   import dii_pkg::*;

   localparam logic [3:0] S_IDLE = 4'd0, S_SRC = 4'd1, S_FLAGS = 4'd2, S_ADDR = 4'd3;
   localparam logic [3:0] S_WDATA = 4'd4, S_DROP = 4'd5, S_EXT = 4'd6;
   localparam logic [3:0] S_RESP_DEST = 4'd7, S_RESP_SRC = 4'd8;
   localparam logic [3:0] S_RESP_FLAGS = 4'd9, S_RESP_VALUE = 4'd10;

   logic [3:0]  state, nxt_state;
   logic        nxt_active;
   logic        req_write, nxt_req_write;
   logic [1:0]  req_size, nxt_req_size;
   logic [15:0] req_addr, nxt_req_addr;
   logic [15:0] value, nxt_value;       // Write data or read result
   logic [15:0] resp_dest, nxt_resp_dest;
   logic        resp_err, nxt_resp_err;
   dii_flags_u  flags_in, flags_out;

   assign flags_in = req.data;
   assign stall = CAN_STALL ? ~active : 1'b0;

   assign mreg.request = (state == S_EXT);
   assign mreg.write   = req_write;
   assign mreg.addr    = req_addr;
   assign mreg.size    = req_size;
   assign mreg.wdata   = value;

   always_ff @(posedge clk) begin
      if (rst) begin
         state  <= S_IDLE;
         active <= 1'b0;
      end else begin
         state  <= nxt_state;
         active <= nxt_active;
      end
      req_write <= nxt_req_write;
      req_size  <= nxt_req_size;
      req_addr  <= nxt_req_addr;
      value     <= nxt_value;
      resp_dest <= nxt_resp_dest;
      resp_err  <= nxt_resp_err;
   end

   always_comb begin
      nxt_state     = state;
      nxt_active    = active;
      nxt_req_write = req_write;
      nxt_req_size  = req_size;
      nxt_req_addr  = req_addr;
      nxt_value     = value;
      nxt_resp_dest = resp_dest;
      nxt_resp_err  = resp_err;
      req.ready     = 1'b0;
      resp.valid    = 1'b0;
      resp.last     = 1'b0;
      resp.data     = 16'h0000;
      flags_out     = '0;

      case (state)
         S_IDLE: begin                                   // Destination word
            req.ready = 1'b1;
            if (req.valid) begin
               nxt_state = req.last ? S_IDLE : S_SRC;
            end
         end
         S_SRC: begin
            req.ready = 1'b1;
            if (req.valid) begin
               nxt_resp_dest = req.data;                 // Answer goes back to the sender
               nxt_resp_err  = 1'b0;
               nxt_state     = req.last ? S_IDLE : S_FLAGS;
            end
         end
         S_FLAGS: begin
            req.ready = 1'b1;
            if (req.valid) begin
               nxt_req_write = flags_in.req.write;
               nxt_req_size  = flags_in.req.size;
               if (req.last) begin
                  nxt_state = S_IDLE;
               end else if (flags_in.req.typ != TYPE_REG) begin
                  nxt_state = S_DROP;
               end else begin
                  nxt_state = S_ADDR;
               end
            end
         end
         S_ADDR: begin
            req.ready = 1'b1;
            if (req.valid) begin
               nxt_req_addr = req.data;
               if (req_write) begin
                  nxt_resp_err = req.last;               // Data word missing
                  nxt_state    = req.last ? S_RESP_DEST : S_WDATA;
               end else if (!req.last) begin
                  nxt_state = S_DROP;
               end else if (req.data >= EXT_ADDR_BASE) begin
                  nxt_state = S_EXT;
               end else begin
                  nxt_state = S_RESP_DEST;
                  case (req.data)
                     REG_MOD_VENDOR:     nxt_value = MOD_VENDOR;
                     REG_MOD_TYPE:       nxt_value = MOD_TYPE;
                     REG_MOD_VERSION:    nxt_value = MOD_VERSION;
                     REG_MOD_CS:         nxt_value = {15'h0000, active};
                     REG_MOD_EVENT_DEST: nxt_value = MOD_EVENT_DEST;
                     default:            nxt_resp_err = 1'b1;
                  endcase
               end
            end
         end
         S_WDATA: begin
            req.ready = 1'b1;
            if (req.valid) begin
               nxt_value = req.data;
               if (!req.last) begin
                  nxt_state = S_DROP;
               end else if (req_addr >= EXT_ADDR_BASE) begin
                  nxt_state = S_EXT;
               end else begin
                  nxt_state = S_RESP_DEST;
                  // Only a 16-bit MOD_CS write is allowed locally
                  if (req_addr == REG_MOD_CS && req_size == SIZE_16) begin
                     nxt_active = req.data[REG_MOD_CS_ACTIVE];
                  end else begin
                     nxt_resp_err = 1'b1;
                  end
               end
            end
         end
         S_DROP: begin                                   // Swallow the rest of the packet
            req.ready = 1'b1;
            if (req.valid && req.last) begin
               nxt_state = S_IDLE;
            end
         end
         S_EXT: begin
            if (mreg.ack || mreg.err) begin
               nxt_value    = mreg.rdata;
               nxt_resp_err = mreg.err;
               nxt_state    = S_RESP_DEST;
            end
         end
         S_RESP_DEST: begin
            resp.valid = 1'b1;
            resp.data  = resp_dest;
            if (resp.ready) begin
               nxt_state = S_RESP_SRC;
            end
         end
         S_RESP_SRC: begin
            resp.valid = 1'b1;
            resp.data  = id;
            if (resp.ready) begin
               nxt_state = S_RESP_FLAGS;
            end
         end
         S_RESP_FLAGS: begin
            flags_out.resp.typ = TYPE_REG;
            if (req_write) begin
               flags_out.resp.subtype = resp_err ? SUB_WRITE_ERR : SUB_WRITE_OK;
            end else begin
               flags_out.resp.subtype = resp_err ? SUB_READ_ERR : {SUB_READ_OK, req_size};
            end
            resp.valid = 1'b1;
            resp.data  = flags_out;
            resp.last  = resp_err || req_write;          // Value word only for good reads
            if (resp.ready) begin
               nxt_state = resp.last ? S_IDLE : S_RESP_VALUE;
            end
         end
         S_RESP_VALUE: begin
            resp.valid = 1'b1;
            resp.data  = value;
            resp.last  = 1'b1;
            if (resp.ready) begin
               nxt_state = S_IDLE;
            end
         end
         default: nxt_state = S_IDLE;
      endcase
   end

   // Bus request stays up with a steady address until the event unit answers
   a_req_held: assert property (@(posedge clk) disable iff (rst)
      mreg.request && !(mreg.ack || mreg.err) |=> mreg.request && $stable(mreg.addr));

   a_half_duplex: assert property (@(posedge clk) disable iff (rst)
      !(resp.valid && req.ready));

endmodule

// File: hw/dii_if.sv
// Flit channel
`timescale 1ns/1ps

interface dii_if;
   logic [15:0] data;
   logic        last;
   logic        valid;
   logic        ready;

   modport sender (
      output data,
      output last,
      output valid,
      input  ready
   );

   modport receiver (
      input  data,
      input  last,
      input  valid,
      output ready
   );

endinterface

// File: hw/dii_pkg.sv
// Debug interconnect definitions
package dii_pkg;

   // Packet types in flags bits 15:14
   localparam logic [1:0] TYPE_REG   = 2'b00;
   localparam logic [1:0] TYPE_EVENT = 2'b10;

   // Access sizes
   localparam logic [1:0] SIZE_16  = 2'b00;
   localparam logic [1:0] SIZE_32  = 2'b01;
   localparam logic [1:0] SIZE_64  = 2'b10;
   localparam logic [1:0] SIZE_128 = 2'b11;

   // Base registers, answered by the register access block
   localparam logic [15:0] REG_MOD_VENDOR     = 16'h0000;
   localparam logic [15:0] REG_MOD_TYPE       = 16'h0001;
   localparam logic [15:0] REG_MOD_VERSION    = 16'h0002;
   localparam logic [15:0] REG_MOD_CS         = 16'h0003;
   localparam logic [15:0] REG_MOD_EVENT_DEST = 16'h0004;
   localparam int          REG_MOD_CS_ACTIVE  = 0;      // Bit position in MOD_CS

   // Module registers live from here upward
   localparam logic [15:0] EXT_ADDR_BASE = 16'h0200;
   localparam logic [15:0] REG_THRESHOLD = 16'h0200;    // Read/write
   localparam logic [15:0] REG_COUNT     = 16'h0201;    // Read only

   // Response subtypes
   localparam logic [3:0] SUB_WRITE_ERR = 4'b1111;
   localparam logic [3:0] SUB_WRITE_OK  = 4'b1110;
   localparam logic [3:0] SUB_READ_ERR  = 4'b1100;
   localparam logic [1:0] SUB_READ_OK   = 2'b10;        // Size goes in the low two bits

   typedef struct packed {
      logic [1:0] typ;
      logic       rsvd_hi;
      logic       write;
      logic [1:0] size;
      logic [9:0] rsvd_lo;
   } dii_req_flags_t;

   typedef struct packed {
      logic [1:0] typ;
      logic [3:0] subtype;
      logic [9:0] rsvd;
   } dii_resp_flags_t;

   // Same flags word, request or response layout
   typedef union packed {
      dii_req_flags_t  req;
      dii_resp_flags_t resp;
   } dii_flags_u;

endpackage

// File: hw/reg_if.sv
// Module register bus
`timescale 1ns/1ps

interface reg_if;
   logic        request;   // Held until ack or err
   logic        write;
   logic [15:0] addr;
   logic [1:0]  size;
   logic [15:0] wdata;
   logic        ack;       // Single cycle
   logic        err;       // Single cycle
   logic [15:0] rdata;

   modport master (
      output request,
      output write,
      output addr,
      output size,
      output wdata,
      input  ack,
      input  err,
      input  rdata
   );

   modport slave (
      input  request,
      input  write,
      input  addr,
      input  size,
      input  wdata,
      output ack,
      output err,
      output rdata
   );

endinterface
